// ==== Bender.yml ====
package:
  name: harvard_mem

sources:
  - design/mem_bus_pkg.sv
  - design/cache_geom_pkg.sv
  - design/cache_ram.sv
  - design/instr_cache.sv
  - design/data_cache.sv
  - design/mem_arbiter.sv
  - design/harvard_mem_top.sv
  - target: test
    files:
      - dv/harvard_mem_tb.sv

// ==== design/cache_geom_pkg.sv ====
// ==============================
// Line geometry common to both caches
// Lines are fixed at 8 words
// ==============================
package cache_geom_pkg;

    localparam int line_words = 8;
    // Word offset inside a line
    localparam int offset_bits = 3;

    // Controller states, st_write only used by the data cache
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_fill,
        st_write,
        st_bypass
    } ctrl_state_e;

endpackage

// ==== design/cache_ram.sv ====
`timescale 1ns/1ps
// ==============================
// Simple dual-port RAM, registered read
// Read during write to the same word returns old data
// ==============================
module cache_ram #(
    parameter int words = 512,
    parameter int width = 16
) (
    input  logic                     clk,
    input  logic [$clog2(words)-1:0] waddr,
    input  logic                     wen,
    input  logic [width-1:0]         wdata,
    input  logic [$clog2(words)-1:0] raddr,
    output logic [width-1:0]         rdata
);

    logic [width-1:0] mem [words];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
        // Sampled before the write lands
        rdata <= mem[raddr];
    end

endmodule

// ==== design/data_cache.sv ====
`timescale 1ns/1ps
// ==============================
// Direct-mapped write-through data cache
// Read misses fill a line, store misses do not allocate
// enabled low sends each access to memory as one word
// ==============================
module data_cache #(
    parameter int lines = 512
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enabled,
    input  mem_bus_pkg::word_addr_t c_addr,
    input  logic                    c_access,
    input  logic                    c_wr,
    input  mem_bus_pkg::word_t      c_wdata,
    output mem_bus_pkg::word_t      c_rdata,
    output logic                    c_ack,
    output mem_bus_pkg::word_addr_t m_addr,
    output logic                    m_access,
    output logic                    m_wr,
    output mem_bus_pkg::word_t      m_wdata,
    input  mem_bus_pkg::word_t      m_rdata,
    input  logic                    m_ack
);

    localparam int index_w = $clog2(lines);
    localparam int line_w  = mem_bus_pkg::addr_w - cache_geom_pkg::offset_bits;
    localparam int tag_w   = line_w - index_w;
    localparam int data_aw = index_w + cache_geom_pkg::offset_bits;

    cache_geom_pkg::ctrl_state_e state;
    logic c_ack_q;
    logic sweeping;
    logic [index_w-1:0] sweep_idx;
    logic [line_w-1:0] fill_line;
    logic [cache_geom_pkg::offset_bits-1:0] fill_cnt;
    logic [tag_w-1:0] tag_rdata;
    logic valid_rdata;
    mem_bus_pkg::word_t data_rdata;
    logic hit;
    logic in_fill;
    logic fill_ack;
    logic fill_last;
    logic store_hit;

    assign hit = valid_rdata && (tag_rdata == c_addr[mem_bus_pkg::addr_w-1 -: tag_w]);
    assign in_fill = (state == cache_geom_pkg::st_fill);
    assign fill_ack = in_fill && m_ack;
    assign fill_last = fill_ack && (int'(fill_cnt) == cache_geom_pkg::line_words - 1);
    // Store hit patches the cached word during lookup
    assign store_hit = (state == cache_geom_pkg::st_lookup) && c_wr && hit;

    assign c_ack = (state == cache_geom_pkg::st_bypass) ? m_ack : c_ack_q;
    assign c_rdata = (state == cache_geom_pkg::st_bypass) ? m_rdata : data_rdata;
    assign m_access = in_fill || (state == cache_geom_pkg::st_write) ||
                      (state == cache_geom_pkg::st_bypass);
    assign m_wr = (state == cache_geom_pkg::st_write) ||
                  ((state == cache_geom_pkg::st_bypass) && c_wr);
    assign m_wdata = c_wdata;
    assign m_addr = in_fill ? {fill_line, fill_cnt} : c_addr;

    cache_ram #(.words(lines), .width(tag_w)) tag_ram (
        .clk   (clk),
        .waddr (fill_line[index_w-1:0]),
        .wen   (fill_last),
        .wdata (fill_line[line_w-1:index_w]),
        .raddr (c_addr[cache_geom_pkg::offset_bits +: index_w]),
        .rdata (tag_rdata)
    );

    cache_ram #(.words(lines), .width(1)) valid_ram (
        .clk   (clk),
        .waddr (sweeping ? sweep_idx : fill_line[index_w-1:0]),
        .wen   (sweeping || fill_last),
        .wdata (!sweeping),
        .raddr (c_addr[cache_geom_pkg::offset_bits +: index_w]),
        .rdata (valid_rdata)
    );

    // Write port shared by line fill and store hit, never active together
    cache_ram #(.words(lines * cache_geom_pkg::line_words), .width(mem_bus_pkg::data_w)) data_ram (
        .clk   (clk),
        .waddr (in_fill ? {fill_line[index_w-1:0], fill_cnt} : c_addr[data_aw-1:0]),
        .wen   (fill_ack || store_hit),
        .wdata (in_fill ? m_rdata : c_wdata),
        .raddr (c_addr[data_aw-1:0]),
        .rdata (data_rdata)
    );

    // Post-reset valid clear, one line per cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sweeping <= 1'b1;
            sweep_idx <= '0;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (&sweep_idx) begin
                sweeping <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == cache_geom_pkg::st_lookup) begin
            fill_line <= c_addr[mem_bus_pkg::addr_w-1:cache_geom_pkg::offset_bits];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cache_geom_pkg::st_idle;
            c_ack_q <= 1'b0;
            fill_cnt <= '0;
        end else begin
            c_ack_q <= 1'b0;
            case (state)
                cache_geom_pkg::st_idle: begin
                    if (c_access && !c_ack_q && !sweeping) begin
                        state <= enabled ? cache_geom_pkg::st_lookup : cache_geom_pkg::st_bypass;
                    end
                end
                // Every store goes out to memory, hit or miss
                cache_geom_pkg::st_lookup: begin
                    if (c_wr) begin
                        state <= cache_geom_pkg::st_write;
                    end else if (hit) begin
                        c_ack_q <= 1'b1;
                        state <= cache_geom_pkg::st_idle;
                    end else begin
                        fill_cnt <= '0;
                        state <= cache_geom_pkg::st_fill;
                    end
                end
                cache_geom_pkg::st_fill: begin
                    if (m_ack) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (fill_last) begin
                            state <= cache_geom_pkg::st_idle;
                        end
                    end
                end
                // Ack to the CPU one cycle behind the memory ack
                cache_geom_pkg::st_write: begin
                    if (m_ack) begin
                        c_ack_q <= 1'b1;
                        state <= cache_geom_pkg::st_idle;
                    end
                end
                cache_geom_pkg::st_bypass: begin
                    if (m_ack) begin
                        state <= cache_geom_pkg::st_idle;
                    end
                end
                default: state <= cache_geom_pkg::st_idle;
            endcase
        end
    end

endmodule

// ==== design/harvard_mem_top.sv ====
`timescale 1ns/1ps
// ==============================
// Instruction and data caches sharing one memory port
// No coherence, stores leave instruction lines alone
// ==============================
module harvard_mem_top #(
    parameter int icache_lines = 512,
    parameter int dcache_lines = 512
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    icache_en,
    input  logic                    dcache_en,
    input  mem_bus_pkg::word_addr_t i_addr,
    input  logic                    i_access,
    output mem_bus_pkg::word_t      i_rdata,
    output logic                    i_ack,
    input  mem_bus_pkg::word_addr_t d_addr,
    input  logic                    d_access,
    input  logic                    d_wr,
    input  mem_bus_pkg::word_t      d_wdata,
    output mem_bus_pkg::word_t      d_rdata,
    output logic                    d_ack,
    output mem_bus_pkg::word_addr_t mem_addr,
    output logic                    mem_access,
    output logic                    mem_wr,
    output mem_bus_pkg::word_t      mem_wdata,
    input  mem_bus_pkg::word_t      mem_rdata,
    input  logic                    mem_ack
);

    // Cache to arbiter links
    mem_bus_pkg::word_addr_t ic_m_addr;
    logic ic_m_access;
    mem_bus_pkg::word_t ic_m_rdata;
    logic ic_m_ack;
    mem_bus_pkg::word_addr_t dc_m_addr;
    logic dc_m_access;
    logic dc_m_wr;
    mem_bus_pkg::word_t dc_m_wdata;
    mem_bus_pkg::word_t dc_m_rdata;
    logic dc_m_ack;

    instr_cache #(.lines(icache_lines)) u_icache (
        .clk      (clk),
        .reset    (reset),
        .enabled  (icache_en),
        .c_addr   (i_addr),
        .c_access (i_access),
        .c_rdata  (i_rdata),
        .c_ack    (i_ack),
        .m_addr   (ic_m_addr),
        .m_access (ic_m_access),
        .m_rdata  (ic_m_rdata),
        .m_ack    (ic_m_ack)
    );

    data_cache #(.lines(dcache_lines)) u_dcache (
        .clk      (clk),
        .reset    (reset),
        .enabled  (dcache_en),
        .c_addr   (d_addr),
        .c_access (d_access),
        .c_wr     (d_wr),
        .c_wdata  (d_wdata),
        .c_rdata  (d_rdata),
        .c_ack    (d_ack),
        .m_addr   (dc_m_addr),
        .m_access (dc_m_access),
        .m_wr     (dc_m_wr),
        .m_wdata  (dc_m_wdata),
        .m_rdata  (dc_m_rdata),
        .m_ack    (dc_m_ack)
    );

    mem_arbiter u_arbiter (
        .clk        (clk),
        .reset      (reset),
        .i_addr     (ic_m_addr),
        .i_access   (ic_m_access),
        .i_rdata    (ic_m_rdata),
        .i_ack      (ic_m_ack),
        .d_addr     (dc_m_addr),
        .d_access   (dc_m_access),
        .d_wr       (dc_m_wr),
        .d_wdata    (dc_m_wdata),
        .d_rdata    (dc_m_rdata),
        .d_ack      (dc_m_ack),
        .mem_addr   (mem_addr),
        .mem_access (mem_access),
        .mem_wr     (mem_wr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ack    (mem_ack)
    );

endmodule

// ==== design/instr_cache.sv ====
`timescale 1ns/1ps
// ==============================
// Read-only direct-mapped cache, whole-line fill
// Requests wait during the post-reset valid sweep
// enabled low sends each fetch to memory as one word
// ==============================
module instr_cache #(
    parameter int lines = 512
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    enabled,
    input  mem_bus_pkg::word_addr_t c_addr,
    input  logic                    c_access,
    output mem_bus_pkg::word_t      c_rdata,
    output logic                    c_ack,
    output mem_bus_pkg::word_addr_t m_addr,
    output logic                    m_access,
    input  mem_bus_pkg::word_t      m_rdata,
    input  logic                    m_ack
);

    localparam int index_w = $clog2(lines);
    localparam int line_w  = mem_bus_pkg::addr_w - cache_geom_pkg::offset_bits;
    localparam int tag_w   = line_w - index_w;
    localparam int data_aw = index_w + cache_geom_pkg::offset_bits;

    cache_geom_pkg::ctrl_state_e state;
    logic c_ack_q;
    logic sweeping;
    logic [index_w-1:0] sweep_idx;
    logic [line_w-1:0] fill_line;
    logic [cache_geom_pkg::offset_bits-1:0] fill_cnt;
    logic [tag_w-1:0] tag_rdata;
    logic valid_rdata;
    mem_bus_pkg::word_t data_rdata;
    logic hit;
    logic fill_ack;
    logic fill_last;

    // RAMs are read at the held CPU address, so lookup sees last cycle's read
    assign hit = valid_rdata && (tag_rdata == c_addr[mem_bus_pkg::addr_w-1 -: tag_w]);
    assign fill_ack = (state == cache_geom_pkg::st_fill) && m_ack;
    assign fill_last = fill_ack && (int'(fill_cnt) == cache_geom_pkg::line_words - 1);

    // Bypass hands the memory ack and data straight back
    assign c_ack = (state == cache_geom_pkg::st_bypass) ? m_ack : c_ack_q;
    assign c_rdata = (state == cache_geom_pkg::st_bypass) ? m_rdata : data_rdata;
    assign m_access = (state == cache_geom_pkg::st_fill) ||
                      (state == cache_geom_pkg::st_bypass);
    assign m_addr = (state == cache_geom_pkg::st_fill) ? {fill_line, fill_cnt} : c_addr;

    // Tag and valid are written together at the last word of a fill
    cache_ram #(.words(lines), .width(tag_w)) tag_ram (
        .clk   (clk),
        .waddr (fill_line[index_w-1:0]),
        .wen   (fill_last),
        .wdata (fill_line[line_w-1:index_w]),
        .raddr (c_addr[cache_geom_pkg::offset_bits +: index_w]),
        .rdata (tag_rdata)
    );

    // The sweep owns the write port until every line is cleared
    cache_ram #(.words(lines), .width(1)) valid_ram (
        .clk   (clk),
        .waddr (sweeping ? sweep_idx : fill_line[index_w-1:0]),
        .wen   (sweeping || fill_last),
        .wdata (!sweeping),
        .raddr (c_addr[cache_geom_pkg::offset_bits +: index_w]),
        .rdata (valid_rdata)
    );

    cache_ram #(.words(lines * cache_geom_pkg::line_words), .width(mem_bus_pkg::data_w)) data_ram (
        .clk   (clk),
        .waddr ({fill_line[index_w-1:0], fill_cnt}),
        .wen   (fill_ack),
        .wdata (m_rdata),
        .raddr (c_addr[data_aw-1:0]),
        .rdata (data_rdata)
    );

    // Clears one valid bit per cycle after reset, line count is a power of two
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sweeping <= 1'b1;
            sweep_idx <= '0;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (&sweep_idx) begin
                sweeping <= 1'b0;
            end
        end
    end

    // Line under fill, taken when the lookup misses
    always_ff @(posedge clk) begin
        if (state == cache_geom_pkg::st_lookup) begin
            fill_line <= c_addr[mem_bus_pkg::addr_w-1:cache_geom_pkg::offset_bits];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cache_geom_pkg::st_idle;
            c_ack_q <= 1'b0;
            fill_cnt <= '0;
        end else begin
            c_ack_q <= 1'b0;
            case (state)
                // Skip the cycle of our own ack, the CPU still holds c_access there
                cache_geom_pkg::st_idle: begin
                    if (c_access && !c_ack_q && !sweeping) begin
                        state <= enabled ? cache_geom_pkg::st_lookup : cache_geom_pkg::st_bypass;
                    end
                end
                cache_geom_pkg::st_lookup: begin
                    if (hit) begin
                        c_ack_q <= 1'b1;
                        state <= cache_geom_pkg::st_idle;
                    end else begin
                        fill_cnt <= '0;
                        state <= cache_geom_pkg::st_fill;
                    end
                end
                // Idle re-runs the lookup once the RAMs read the new line
                cache_geom_pkg::st_fill: begin
                    if (m_ack) begin
                        fill_cnt <= fill_cnt + 1'b1;
                        if (fill_last) begin
                            state <= cache_geom_pkg::st_idle;
                        end
                    end
                end
                cache_geom_pkg::st_bypass: begin
                    if (m_ack) begin
                        state <= cache_geom_pkg::st_idle;
                    end
                end
                default: state <= cache_geom_pkg::st_idle;
            endcase
        end
    end

endmodule

// ==== design/mem_arbiter.sv ====
`timescale 1ns/1ps
// ==============================
// Two-way arbiter for the memory port
// Grant holds until the owner drops its access
// ==============================
module mem_arbiter (
    input  logic                    clk,
    input  logic                    reset,
    input  mem_bus_pkg::word_addr_t i_addr,
    input  logic                    i_access,
    output mem_bus_pkg::word_t      i_rdata,
    output logic                    i_ack,
    input  mem_bus_pkg::word_addr_t d_addr,
    input  logic                    d_access,
    input  logic                    d_wr,
    input  mem_bus_pkg::word_t      d_wdata,
    output mem_bus_pkg::word_t      d_rdata,
    output logic                    d_ack,
    output mem_bus_pkg::word_addr_t mem_addr,
    output logic                    mem_access,
    output logic                    mem_wr,
    output mem_bus_pkg::word_t      mem_wdata,
    input  mem_bus_pkg::word_t      mem_rdata,
    input  logic                    mem_ack
);

    mem_bus_pkg::owner_e owner;
    logic i_own;
    logic d_own;
    // Set when the data cache held the port last
    logic last_dcache;

    assign i_own = (owner == mem_bus_pkg::owner_icache);
    assign d_own = (owner == mem_bus_pkg::owner_dcache);

    // Memory sees nothing until the grant lands
    assign mem_access = (i_own && i_access) || (d_own && d_access);
    assign mem_addr = d_own ? d_addr : i_addr;
    assign mem_wr = d_own && d_wr;
    assign mem_wdata = d_wdata;

    assign i_ack = i_own && mem_ack;
    assign d_ack = d_own && mem_ack;
    assign i_rdata = i_own ? mem_rdata : '0;
    assign d_rdata = d_own ? mem_rdata : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            owner <= mem_bus_pkg::owner_none;
            last_dcache <= 1'b0;
        end else begin
            case (owner)
                // On a tie the side that waited last time wins
                mem_bus_pkg::owner_none: begin
                    if (i_access && (!d_access || last_dcache)) begin
                        owner <= mem_bus_pkg::owner_icache;
                        last_dcache <= 1'b0;
                    end else if (d_access) begin
                        owner <= mem_bus_pkg::owner_dcache;
                        last_dcache <= 1'b1;
                    end
                end
                mem_bus_pkg::owner_icache: if (!i_access) owner <= mem_bus_pkg::owner_none;
                mem_bus_pkg::owner_dcache: if (!d_access) owner <= mem_bus_pkg::owner_none;
                default: owner <= mem_bus_pkg::owner_none;
            endcase
        end
    end

endmodule

// ==== design/mem_bus_pkg.sv ====
// ==============================
// Word-wide memory bus shared by both caches
// Addresses count 16-bit words, no byte lanes
// ==============================
package mem_bus_pkg;

    // Word address covers byte address bits 19 down to 1
    localparam int addr_w = 19;
    localparam int data_w = 16;

    typedef logic [addr_w-1:0] word_addr_t;
    typedef logic [data_w-1:0] word_t;

    // Holder of the single memory port
    typedef enum logic [1:0] {
        owner_none,
        owner_icache,
        owner_dcache
    } owner_e;

endpackage

// ==== dv/harvard_mem_tb.sv ====
`timescale 1ns/1ps
// ==============================
// Directed tests for the cache pair and arbiter
// Memory answers after 1 to 4 cycles and holds a pure address function
// Caches built with 16 lines to keep the reset sweep short
// ==============================
module harvard_mem_tb;

    localparam int clk_period = 40;
    localparam int cache_lines = 16;
    localparam int random_ops = 40;
    // Accesses of the fixed tests plus the random mix
    localparam int total_accesses = 13 + random_ops;
    // Each access may need 8 words at about 6 cycles and the total is doubled for margin
    localparam int timeout_ns = total_accesses * 8 * 6 * clk_period * 2;
    localparam logic [31:0] rng_seed = 32'h430d_7843;

    logic clk;
    logic reset;
    logic icache_en;
    logic dcache_en;
    mem_bus_pkg::word_addr_t i_addr;
    logic i_access;
    mem_bus_pkg::word_t i_rdata;
    logic i_ack;
    mem_bus_pkg::word_addr_t d_addr;
    logic d_access;
    logic d_wr;
    mem_bus_pkg::word_t d_wdata;
    mem_bus_pkg::word_t d_rdata;
    logic d_ack;
    mem_bus_pkg::word_addr_t mem_addr;
    logic mem_access;
    logic mem_wr;
    mem_bus_pkg::word_t mem_wdata;
    mem_bus_pkg::word_t mem_rdata;
    logic mem_ack;

    logic [31:0] rng_state = rng_seed;
    // Memory model storage and the expected image kept by the tests
    mem_bus_pkg::word_t shadow_mem [int];
    mem_bus_pkg::word_t expect_mem [int];
    mem_bus_pkg::word_addr_t addr_log [$];
    int read_count;
    int write_count;
    int check_count;
    int error_count;
    int test_count;

    harvard_mem_top #(
        .icache_lines (cache_lines),
        .dcache_lines (cache_lines)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .icache_en  (icache_en),
        .dcache_en  (dcache_en),
        .i_addr     (i_addr),
        .i_access   (i_access),
        .i_rdata    (i_rdata),
        .i_ack      (i_ack),
        .d_addr     (d_addr),
        .d_access   (d_access),
        .d_wr       (d_wr),
        .d_wdata    (d_wdata),
        .d_rdata    (d_rdata),
        .d_ack      (d_ack),
        .mem_addr   (mem_addr),
        .mem_access (mem_access),
        .mem_wr     (mem_wr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ack    (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Linear congruential generator whose upper bits are the useful ones
    function logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Power-up memory content where every address bit takes part
    function automatic mem_bus_pkg::word_t init_word(input mem_bus_pkg::word_addr_t a);
        return {a[12:0], a[15:13]} ^ {a[18:16], 13'h0} ^ 16'h9e37;
    endfunction

    function automatic mem_bus_pkg::word_t shadow_word(input mem_bus_pkg::word_addr_t a);
        return shadow_mem.exists(int'(a)) ? shadow_mem[int'(a)] : init_word(a);
    endfunction

    function automatic mem_bus_pkg::word_t expected_word(input mem_bus_pkg::word_addr_t a);
        return expect_mem.exists(int'(a)) ? expect_mem[int'(a)] : init_word(a);
    endfunction

    // Memory model that samples the request at the falling edge
    initial begin
        mem_bus_pkg::word_addr_t req_addr;
        logic req_wr;
        mem_bus_pkg::word_t req_wdata;
        int delay;
        forever begin
            @(negedge clk);
            if (mem_access) begin
                req_addr = mem_addr;
                req_wr = mem_wr;
                req_wdata = mem_wdata;
                delay = 1 + int'((lcg_next() >> 16) % 4);
                repeat (delay) @(posedge clk);
                #2;
                addr_log.push_back(req_addr);
                if (req_wr) begin
                    shadow_mem[int'(req_addr)] = req_wdata;
                    write_count++;
                end else begin
                    mem_rdata = shadow_word(req_addr);
                    read_count++;
                end
                mem_ack = 1'b1;
                @(posedge clk);
                #2;
                mem_ack = 1'b0;
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("Watchdog expired, the DUT stopped answering before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        $display("%s finished with %0d errors", name, error_count - errors_before);
    endtask

    task automatic clear_counts();
        read_count = 0;
        write_count = 0;
        addr_log.delete();
    endtask

    // Eight logged reads starting at offset 0 of the line holding addr
    task automatic check_burst(input string name, input int first,
                               input mem_bus_pkg::word_addr_t addr);
        for (int k = 0; k < cache_geom_pkg::line_words; k++) begin
            check_value(name, {addr[18:3], 3'(k)}, addr_log[first + k]);
        end
    endtask

    task automatic fetch(input mem_bus_pkg::word_addr_t addr,
                         output mem_bus_pkg::word_t data);
        @(posedge clk);
        #2;
        i_addr = addr;
        i_access = 1'b1;
        @(negedge clk);
        while (!i_ack) @(negedge clk);
        data = i_rdata;
        // Drop the request in the cycle after the ack
        @(posedge clk);
        #2;
        i_access = 1'b0;
    endtask

    task automatic data_access(input logic wr, input mem_bus_pkg::word_addr_t addr,
                               input mem_bus_pkg::word_t wdata,
                               output mem_bus_pkg::word_t rdata);
        @(posedge clk);
        #2;
        d_addr = addr;
        d_wr = wr;
        d_wdata = wdata;
        d_access = 1'b1;
        @(negedge clk);
        while (!d_ack) @(negedge clk);
        rdata = d_rdata;
        @(posedge clk);
        #2;
        d_access = 1'b0;
        d_wr = 1'b0;
    endtask

    task automatic load(input mem_bus_pkg::word_addr_t addr, output mem_bus_pkg::word_t data);
        data_access(1'b0, addr, '0, data);
    endtask

    // Every store reaches memory, so the expected image follows it
    task automatic store(input mem_bus_pkg::word_addr_t addr, input mem_bus_pkg::word_t wdata);
        mem_bus_pkg::word_t unused;
        data_access(1'b1, addr, wdata, unused);
        expect_mem[int'(addr)] = wdata;
    endtask

    task automatic instr_miss_then_hit();
        string name = "instr_miss_hit";
        int errors_before;
        mem_bus_pkg::word_t data;
        errors_before = error_count;
        clear_counts();
        fetch(19'h00123, data);
        check_value(name, expected_word(19'h00123), data);
        check_value(name, 8, read_count);
        check_burst(name, 0, 19'h00123);
        // Same line needs no memory traffic
        clear_counts();
        fetch(19'h00126, data);
        check_value(name, expected_word(19'h00126), data);
        check_value(name, 0, read_count);
        finish_test(name, errors_before);
    endtask

    task automatic store_write_through();
        string name = "write_through";
        int errors_before;
        mem_bus_pkg::word_t data;
        errors_before = error_count;
        clear_counts();
        store(19'h02345, 16'hbeef);
        check_value(name, 1, write_count);
        check_value(name, 0, read_count);
        check_value(name, 16'hbeef, shadow_word(19'h02345));
        load(19'h02345, data);
        check_value(name, expected_word(19'h02345), data);
        finish_test(name, errors_before);
    endtask

    task automatic store_hit_update();
        string name = "store_hit";
        int errors_before;
        mem_bus_pkg::word_t data;
        errors_before = error_count;
        load(19'h03452, data);
        check_value(name, expected_word(19'h03452), data);
        clear_counts();
        store(19'h03452, 16'h1c3a);
        load(19'h03452, data);
        check_value(name, expected_word(19'h03452), data);
        check_value(name, 1, write_count);
        check_value(name, 0, read_count);
        finish_test(name, errors_before);
    endtask

    task automatic concurrent_misses();
        string name = "concurrent_miss";
        int errors_before;
        mem_bus_pkg::word_t idata;
        mem_bus_pkg::word_t ddata;
        errors_before = error_count;
        clear_counts();
        fork
            fetch(19'h04207, idata);
            load(19'h05361, ddata);
        join
        check_value(name, expected_word(19'h04207), idata);
        check_value(name, expected_word(19'h05361), ddata);
        check_value(name, 16, read_count);
        // The data cache held the port last, so the fetch burst wins the tie
        check_burst(name, 0, 19'h04207);
        check_burst(name, 8, 19'h05361);
        finish_test(name, errors_before);
    endtask

    task automatic bypass_reads();
        string name = "bypass";
        int errors_before;
        mem_bus_pkg::word_t data;
        errors_before = error_count;
        @(posedge clk);
        #2;
        icache_en = 1'b0;
        dcache_en = 1'b0;
        // Both addresses sit in cached lines yet each read goes out
        for (int rep = 0; rep < 2; rep++) begin
            clear_counts();
            fetch(19'h00123, data);
            check_value(name, expected_word(19'h00123), data);
            check_value(name, 1, read_count);
            clear_counts();
            load(19'h03452, data);
            check_value(name, expected_word(19'h03452), data);
            check_value(name, 1, read_count);
        end
        @(posedge clk);
        #2;
        icache_en = 1'b1;
        dcache_en = 1'b1;
        finish_test(name, errors_before);
    endtask

    // Regions of 512 words give four tags on each of the 16 indexes
    task automatic random_mix();
        string name = "random_mix";
        int errors_before;
        logic [31:0] r;
        mem_bus_pkg::word_addr_t addr;
        mem_bus_pkg::word_t data;
        errors_before = error_count;
        for (int i = 0; i < random_ops; i++) begin
            r = lcg_next();
            case ((r >> 28) % 3)
                0: begin
                    // Instruction region is never stored to
                    addr = 19'h50000 | 19'(r[24:16]);
                    fetch(addr, data);
                    check_value(name, expected_word(addr), data);
                end
                1: begin
                    addr = 19'h10000 | 19'(r[24:16]);
                    load(addr, data);
                    check_value(name, expected_word(addr), data);
                end
                default: begin
                    addr = 19'h10000 | 19'(r[24:16]);
                    store(addr, 16'(lcg_next() >> 16));
                end
            endcase
        end
        finish_test(name, errors_before);
    endtask

    initial begin
        reset = 1'b1;
        icache_en = 1'b1;
        dcache_en = 1'b1;
        i_addr = '0;
        i_access = 1'b0;
        d_addr = '0;
        d_access = 1'b0;
        d_wr = 1'b0;
        d_wdata = '0;
        mem_rdata = '0;
        mem_ack = 1'b0;
        read_count = 0;
        write_count = 0;
        check_count = 0;
        error_count = 0;
        test_count = 0;
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;
        // First requests simply wait out the valid sweep
        instr_miss_then_hit();
        store_write_through();
        store_hit_update();
        concurrent_misses();
        bypass_reads();
        random_mix();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
design/mem_bus_pkg.sv
design/cache_geom_pkg.sv
design/cache_ram.sv
design/instr_cache.sv
design/data_cache.sv
design/mem_arbiter.sv
design/harvard_mem_top.sv
dv/harvard_mem_tb.sv
